// ==== source/exe_pkg.sv ====
package exe_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    localparam int DATA_W   = 32;
    localparam int REG_W    = 5;
    localparam int ALU_OP_W = 4;
    localparam int MEM_OP_W = 4;
    localparam int EXC_W    = 5;

    // ------------------------------
    // alu operations
    // ------------------------------
    localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;  // traps on overflow
    localparam logic [ALU_OP_W-1:0] ALU_ADDU = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd2;  // traps on overflow
    localparam logic [ALU_OP_W-1:0] ALU_SUBU = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_NOR  = 4'd9;
    // shifts take the amount from src0 and the value from src1
    localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd10;
    localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd11;
    localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'd12;
    localparam logic [ALU_OP_W-1:0] ALU_LUI  = 4'd13;

    // ------------------------------
    // memory operations
    // ------------------------------
    localparam logic [MEM_OP_W-1:0] MEM_NONE = 4'd0;
    localparam logic [MEM_OP_W-1:0] MEM_LB   = 4'd1;
    localparam logic [MEM_OP_W-1:0] MEM_LBU  = 4'd2;
    localparam logic [MEM_OP_W-1:0] MEM_LH   = 4'd3;
    localparam logic [MEM_OP_W-1:0] MEM_LHU  = 4'd4;
    localparam logic [MEM_OP_W-1:0] MEM_LW   = 4'd5;
    localparam logic [MEM_OP_W-1:0] MEM_SB   = 4'd6;
    localparam logic [MEM_OP_W-1:0] MEM_SH   = 4'd7;
    localparam logic [MEM_OP_W-1:0] MEM_SW   = 4'd8;
    localparam logic [MEM_OP_W-1:0] MEM_SWL  = 4'd9;  // left part of an unaligned word
    localparam logic [MEM_OP_W-1:0] MEM_SWR  = 4'd10; // right part of an unaligned word

    // ------------------------------
    // exception codes in cp0 cause encoding
    // ------------------------------
    localparam logic [EXC_W-1:0] EXC_ADEL = 5'd4;   // address error on load
    localparam logic [EXC_W-1:0] EXC_ADES = 5'd5;   // address error on store
    localparam logic [EXC_W-1:0] EXC_OV   = 5'd12;  // arithmetic overflow

endpackage

// ==== source/exe_op_if.sv ====
interface exe_op_if;
    import exe_pkg::*;

    logic [ALU_OP_W-1:0] alu_op;
    logic [DATA_W-1:0]   src0;
    logic [DATA_W-1:0]   src1;
    logic [MEM_OP_W-1:0] mem_op;
    logic [DATA_W-1:0]   rt_data;      // store data
    logic                in_exc;       // exception raised before execute
    logic [EXC_W-1:0]    in_exc_code;
    logic [DATA_W-1:0]   in_bad_vaddr;
    logic                valid;

    // stage register owns everything
    modport stage (output alu_op, src0, src1, mem_op, rt_data,
                   output in_exc, in_exc_code, in_bad_vaddr, valid);

    modport alu   (input alu_op, src0, src1);

    modport store (input mem_op, rt_data, valid);

    modport check (input mem_op, in_exc, in_exc_code, in_bad_vaddr);

endinterface

// ==== source/exe_stage_reg.sv ====
module exe_stage_reg (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        flush,
    input  logic                        id_valid,
    input  logic [exe_pkg::ALU_OP_W-1:0] id_alu_op,
    input  logic [exe_pkg::DATA_W-1:0]   id_src0,
    input  logic [exe_pkg::DATA_W-1:0]   id_src1,
    input  logic [exe_pkg::MEM_OP_W-1:0] id_mem_op,
    input  logic [exe_pkg::DATA_W-1:0]   id_rt_data,
    input  logic [exe_pkg::REG_W-1:0]    id_wnum,
    input  logic [exe_pkg::DATA_W-1:0]   id_pc,
    input  logic                        id_exc,
    input  logic [exe_pkg::EXC_W-1:0]    id_exc_code,
    input  logic [exe_pkg::DATA_W-1:0]   id_bad_vaddr,
    input  logic                        mem_allowin,
    output logic                        exe_allowin,
    output logic                        exe_valid,
    output logic [exe_pkg::REG_W-1:0]    exe_wnum,
    output logic [exe_pkg::DATA_W-1:0]   exe_pc,
    output logic [exe_pkg::MEM_OP_W-1:0] exe_mem_op,
    exe_op_if.stage                     op
);

    logic valid_r;
    logic load;

    assign exe_allowin = !valid_r || mem_allowin;
    assign exe_valid   = valid_r;
    assign load        = exe_allowin && id_valid && !flush;

    // ------------------------------
    // valid bit
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            valid_r <= 1'b0;               // flush beats a new load
        end else if (exe_allowin) begin
            valid_r <= id_valid;
        end
    end

    // ------------------------------
    // instruction fields
    // ------------------------------
    always_ff @(posedge clk) begin
        if (load) begin
            op.alu_op       <= id_alu_op;
            op.src0         <= id_src0;
            op.src1         <= id_src1;
            op.mem_op       <= id_mem_op;
            op.rt_data      <= id_rt_data;
            op.in_exc       <= id_exc;
            op.in_exc_code  <= id_exc_code;
            op.in_bad_vaddr <= id_bad_vaddr;
            exe_wnum        <= id_wnum;
            exe_pc          <= id_pc;
        end
    end

    assign op.valid   = valid_r;
    assign exe_mem_op = op.mem_op;   // load side is resolved in mem

endmodule

// ==== source/exe_alu.sv ====
module exe_alu (
    exe_op_if.alu                     op,
    output logic [exe_pkg::DATA_W-1:0] result,
    output logic                      overflow
);
    import exe_pkg::*;

    logic [DATA_W-1:0] sum;
    logic [DATA_W-1:0] diff;
    logic [4:0]        shamt;
    logic              add_ov;
    logic              sub_ov;

    assign sum   = op.src0 + op.src1;
    assign diff  = op.src0 - op.src1;
    assign shamt = op.src0[4:0];

    // same-sign operands, result sign flipped
    assign add_ov = (op.src0[DATA_W-1] == op.src1[DATA_W-1]) &&
                    (sum[DATA_W-1] != op.src0[DATA_W-1]);
    // opposite-sign operands, result sign differs from src0
    assign sub_ov = (op.src0[DATA_W-1] != op.src1[DATA_W-1]) &&
                    (diff[DATA_W-1] != op.src0[DATA_W-1]);

    always_comb begin
        result   = '0;
        overflow = 1'b0;
        case (op.alu_op)
            ALU_ADD: begin
                result   = sum;
                overflow = add_ov;
            end
            ALU_ADDU: result = sum;
            ALU_SUB: begin
                result   = diff;
                overflow = sub_ov;
            end
            ALU_SUBU: result = diff;
            ALU_SLT:  result = {{(DATA_W-1){1'b0}}, $signed(op.src0) < $signed(op.src1)};
            ALU_SLTU: result = {{(DATA_W-1){1'b0}}, op.src0 < op.src1};
            ALU_AND:  result = op.src0 & op.src1;
            ALU_OR:   result = op.src0 | op.src1;
            ALU_XOR:  result = op.src0 ^ op.src1;
            ALU_NOR:  result = ~(op.src0 | op.src1);
            ALU_SLL:  result = op.src1 << shamt;
            ALU_SRL:  result = op.src1 >> shamt;
            ALU_SRA:  result = $unsigned($signed(op.src1) >>> shamt);
            ALU_LUI:  result = {op.src1[15:0], 16'h0000};
            default:  result = '0;
        endcase
    end

endmodule

// ==== source/store_align.sv ====
module store_align (
    exe_op_if.store                   op,
    input  logic [exe_pkg::DATA_W-1:0] addr,
    input  logic                      exception,
    output logic [exe_pkg::DATA_W-1:0] dm_wdata,
    output logic [3:0]                dm_we
);
    import exe_pkg::*;

    logic [1:0]        a;
    logic [4:0]        shl;       // 8 * a
    logic [4:0]        shr;       // 8 * (3 - a)
    logic [3:0]        lane_we;
    logic [DATA_W-1:0] rt;

    assign a   = addr[1:0];
    assign rt  = op.rt_data;
    assign shl = {a, 3'b000};
    assign shr = {~a, 3'b000};    // ~a == 3 - a on two bits

    // ------------------------------
    // lane placement, little endian
    // ------------------------------
    always_comb begin
        dm_wdata = rt;
        lane_we  = 4'b0000;       // loads and none write nothing
        case (op.mem_op)
            MEM_SB: begin
                dm_wdata = {4{rt[7:0]}};
                lane_we  = 4'b0001 << a;
            end
            MEM_SH: begin
                dm_wdata = {2{rt[15:0]}};
                lane_we  = a[1] ? 4'b1100 : 4'b0011;
            end
            MEM_SW: begin
                dm_wdata = rt;
                lane_we  = 4'b1111;
            end
            MEM_SWL: begin
                // high bytes of rt land in lanes 0..a
                dm_wdata = rt >> shr;
                lane_we  = 4'b1111 >> ~a;
            end
            MEM_SWR: begin
                // low bytes of rt land in lanes a..3
                dm_wdata = rt << shl;
                lane_we  = 4'b1111 << a;
            end
            default: begin
                dm_wdata = rt;
                lane_we  = 4'b0000;
            end
        endcase
    end

    // empty stage or faulting instruction writes nothing
    assign dm_we = (op.valid && !exception) ? lane_we : 4'b0000;

endmodule

// ==== source/exc_resolve.sv ====
module exc_resolve (
    exe_op_if.check                   op,
    input  logic [exe_pkg::DATA_W-1:0] addr,
    input  logic                      overflow,
    output logic                      exception,
    output logic [exe_pkg::EXC_W-1:0]  exc_code,
    output logic [exe_pkg::DATA_W-1:0] bad_vaddr
);
    import exe_pkg::*;

    logic             adr_fault;
    logic [EXC_W-1:0] adr_code;

    // swl/swr and byte ops never fault
    always_comb begin
        adr_fault = 1'b0;
        adr_code  = EXC_ADEL;
        case (op.mem_op)
            MEM_LH, MEM_LHU: adr_fault = addr[0];
            MEM_LW:          adr_fault = |addr[1:0];
            MEM_SH: begin
                adr_fault = addr[0];
                adr_code  = EXC_ADES;
            end
            MEM_SW: begin
                adr_fault = |addr[1:0];
                adr_code  = EXC_ADES;
            end
            default: adr_fault = 1'b0;
        endcase
    end

    // decode exception first, then overflow, then alignment
    assign exception = op.in_exc || overflow || adr_fault;
    assign exc_code  = op.in_exc ? op.in_exc_code :
                       overflow  ? EXC_OV :
                       adr_fault ? adr_code : '0;
    assign bad_vaddr = op.in_exc ? op.in_bad_vaddr : addr;

endmodule

// ==== source/exe_stage.sv ====
module exe_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        flush,          // from writeback
    input  logic                        id_valid,
    input  logic [exe_pkg::ALU_OP_W-1:0] id_alu_op,
    input  logic [exe_pkg::DATA_W-1:0]   id_src0,
    input  logic [exe_pkg::DATA_W-1:0]   id_src1,
    input  logic [exe_pkg::MEM_OP_W-1:0] id_mem_op,
    input  logic [exe_pkg::DATA_W-1:0]   id_rt_data,
    input  logic [exe_pkg::REG_W-1:0]    id_wnum,
    input  logic [exe_pkg::DATA_W-1:0]   id_pc,
    input  logic                        id_exc,
    input  logic [exe_pkg::EXC_W-1:0]    id_exc_code,
    input  logic [exe_pkg::DATA_W-1:0]   id_bad_vaddr,
    input  logic                        mem_allowin,
    output logic                        exe_allowin,
    output logic                        exe_valid,
    output logic [exe_pkg::DATA_W-1:0]   exe_result,     // also the data address
    output logic [exe_pkg::MEM_OP_W-1:0] exe_mem_op,
    output logic [exe_pkg::REG_W-1:0]    exe_wnum,
    output logic [exe_pkg::DATA_W-1:0]   exe_pc,
    output logic [exe_pkg::DATA_W-1:0]   dm_wdata,
    output logic [3:0]                  dm_we,
    output logic                        exe_exc,
    output logic [exe_pkg::EXC_W-1:0]    exe_exc_code,
    output logic [exe_pkg::DATA_W-1:0]   exe_bad_vaddr
);
    import exe_pkg::*;

    logic [DATA_W-1:0] alu_result;
    logic              overflow;
    logic              exception;

    exe_op_if u_op ();

    // ------------------------------
    // pipeline register
    // ------------------------------
    exe_stage_reg u_stage_reg (
        .clk(clk), .rst_n(rst_n), .flush(flush), .id_valid(id_valid),
        .id_alu_op(id_alu_op), .id_src0(id_src0), .id_src1(id_src1),
        .id_mem_op(id_mem_op), .id_rt_data(id_rt_data), .id_wnum(id_wnum),
        .id_pc(id_pc), .id_exc(id_exc), .id_exc_code(id_exc_code),
        .id_bad_vaddr(id_bad_vaddr), .mem_allowin(mem_allowin),
        .exe_allowin(exe_allowin), .exe_valid(exe_valid), .exe_wnum(exe_wnum),
        .exe_pc(exe_pc), .exe_mem_op(exe_mem_op), .op(u_op.stage)
    );

    // ------------------------------
    // combinational datapath
    // ------------------------------
    exe_alu u_alu (.op(u_op.alu), .result(alu_result), .overflow(overflow));

    store_align u_store_align (
        .op(u_op.store), .addr(alu_result), .exception(exception),
        .dm_wdata(dm_wdata), .dm_we(dm_we)
    );

    exc_resolve u_exc_resolve (
        .op(u_op.check), .addr(alu_result), .overflow(overflow),
        .exception(exception), .exc_code(exe_exc_code), .bad_vaddr(exe_bad_vaddr)
    );

    assign exe_result = alu_result;
    assign exe_exc    = exception;

endmodule

// ==== verification/exe_stage_tb.sv ====
module exe_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import exe_pkg::*;

    logic                clk = 1'b0;
    logic                rst_n, flush, id_valid, id_exc, mem_allowin;
    logic [ALU_OP_W-1:0] id_alu_op;
    logic [MEM_OP_W-1:0] id_mem_op, exe_mem_op;
    logic [DATA_W-1:0]   id_src0, id_src1, id_rt_data, id_pc, id_bad_vaddr;
    logic [REG_W-1:0]    id_wnum, exe_wnum;
    logic [EXC_W-1:0]    id_exc_code, exe_exc_code;
    logic                exe_allowin, exe_valid, exe_exc;
    logic [DATA_W-1:0]   exe_result, exe_pc, dm_wdata, exe_bad_vaddr;
    logic [3:0]          dm_we;

    // model of the stage contents
    logic                m_valid = 1'b0;
    logic                m_exc, hold;
    logic [ALU_OP_W-1:0] m_alu;
    logic [MEM_OP_W-1:0] m_mem;
    logic [DATA_W-1:0]   m_src0, m_src1, m_rt, m_pc, m_bad;
    logic [REG_W-1:0]    m_wnum;
    logic [EXC_W-1:0]    m_code;
    logic [31:0]         rng = 32'd90578;
    int                  checks, errors, tests, seq, accepted, handed, flushed;

    exe_stage u_dut (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // half the values sit next to the signed limits
    function automatic logic [31:0] near_limit(input logic [31:0] r);
        return r[31] ? {r[0], {27{~r[0]}}, r[4:1]} : r;
    endfunction

    // ------------------------------
    // reference model
    // ------------------------------
    function automatic logic [32:0] alu_model(input logic [3:0] op, input logic [31:0] a, b);
        logic [32:0] sum;
        logic [32:0] dif;
        logic [32:0] udif;
        logic [31:0] fill;
        sum  = {a[31], a} + {b[31], b};   // bit 32 is the true sign
        dif  = {a[31], a} - {b[31], b};
        udif = {1'b0, a} - {1'b0, b};     // borrow means a < b
        fill = b[31] ? ~(32'hffff_ffff >> a[4:0]) : 32'd0;
        case (op)
            ALU_ADD:  return {sum[32] != sum[31], sum[31:0]};
            ALU_ADDU: return {1'b0, sum[31:0]};
            ALU_SUB:  return {dif[32] != dif[31], dif[31:0]};
            ALU_SUBU: return {1'b0, dif[31:0]};
            ALU_SLT:  return {32'd0, dif[32]};
            ALU_SLTU: return {32'd0, udif[32]};
            ALU_AND:  return {1'b0, a & b};
            ALU_OR:   return {1'b0, a | b};
            ALU_XOR:  return {1'b0, a ^ b};
            ALU_NOR:  return {1'b0, ~(a | b)};
            ALU_SLL:  return {1'b0, b << a[4:0]};
            ALU_SRL:  return {1'b0, b >> a[4:0]};
            ALU_SRA:  return {1'b0, (b >> a[4:0]) | fill};
            ALU_LUI:  return {1'b0, b[15:0], 16'h0000};
            default:  return 33'd0;
        endcase
    endfunction

    function automatic logic [3:0] lane_range(input int lo, input int hi);
        logic [3:0] m;
        for (int i = 0; i < 4; i++) begin
            m[i] = (i >= lo) && (i <= hi);
        end
        return m;
    endfunction

    // {enables, write word}
    function automatic logic [35:0] store_model(input logic [3:0] mem, input logic [1:0] addr,
                                                input logic [31:0] rt);
        int a;
        a = int'(addr);
        case (mem)
            MEM_SB:  return {lane_range(a, a), {4{rt[7:0]}}};
            MEM_SH:  return {lane_range(a & 2, (a & 2) + 1), {2{rt[15:0]}}};
            MEM_SW:  return {4'b1111, rt};
            MEM_SWL: return {lane_range(0, a), rt >> (8 * (3 - a))};
            MEM_SWR: return {lane_range(a, 3), rt << (8 * a)};
            default: return {4'b0000, rt};
        endcase
    endfunction

    // {fault, code}
    function automatic logic [5:0] fault_model(input logic [3:0] mem, input logic [31:0] addr);
        case (mem)
            MEM_LH, MEM_LHU: return {addr[0], EXC_ADEL};
            MEM_LW:          return {addr[1:0] != 2'b00, EXC_ADEL};
            MEM_SH:          return {addr[0], EXC_ADES};
            MEM_SW:          return {addr[1:0] != 2'b00, EXC_ADES};
            default:         return {1'b0, EXC_ADEL};
        endcase
    endfunction

    function automatic logic [31:0] byte_mask(input logic [3:0] we);
        return {{8{we[3]}}, {8{we[2]}}, {8{we[1]}}, {8{we[0]}}};
    endfunction

    task automatic check_value(input string name, input logic [31:0] act, input logic [31:0] exp);
        checks++;
        assert (act === exp) else begin
            $display("Fail at %0t: %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_outputs();
        logic [32:0] ar;
        logic [35:0] st;
        logic [5:0]  fc;
        logic        e_exc;
        logic [4:0]  e_code;
        check_value("exe_valid", 32'(exe_valid), 32'(m_valid));
        check_value("exe_allowin", 32'(exe_allowin), 32'(!m_valid || mem_allowin));
        if (!m_valid) begin
            check_value("dm_we", 32'(dm_we), 32'd0);   // empty stage
            return;
        end
        ar     = alu_model(m_alu, m_src0, m_src1);
        fc     = fault_model(m_mem, ar[31:0]);
        st     = store_model(m_mem, ar[1:0], m_rt);
        e_exc  = m_exc || ar[32] || fc[5];
        e_code = m_exc ? m_code : ar[32] ? EXC_OV : fc[4:0];
        check_value("exe_result", exe_result, ar[31:0]);
        check_value("exe_mem_op", 32'(exe_mem_op), 32'(m_mem));
        check_value("exe_wnum", 32'(exe_wnum), 32'(m_wnum));
        check_value("exe_pc", exe_pc, m_pc);
        check_value("exe_exc", 32'(exe_exc), 32'(e_exc));
        if (e_exc) begin
            check_value("exe_exc_code", 32'(exe_exc_code), 32'(e_code));
            check_value("exe_bad_vaddr", exe_bad_vaddr, m_exc ? m_bad : ar[31:0]);
        end
        check_value("dm_we", 32'(dm_we), 32'(e_exc ? 4'b0000 : st[35:32]));
        check_value("dm_wdata", dm_wdata & byte_mask(dm_we), st[31:0] & byte_mask(dm_we));
    endtask

    // ------------------------------
    // stimulus
    // ------------------------------
    task automatic drive_inputs(input int mode);
        logic [31:0] r;
        r = xorshift();
        if (mode == 4) begin                // idle
            id_valid    = 1'b0;
            mem_allowin = 1'b1;
            flush       = 1'b0;
            return;
        end
        mem_allowin = (mode == 3) ? r[0] : (r[1:0] != 2'b00);
        flush       = (mode == 3) ? (r[4:2] == 3'd0) : (r[6:2] == 5'd0);
        if (hold) return;                   // decode keeps its instruction
        id_valid     = r[8:7] != 2'b00;
        id_alu_op    = 4'(xorshift() % 14);
        id_mem_op    = (mode == 0) ? MEM_NONE : 4'(xorshift() % 11);
        id_src0      = near_limit(xorshift());
        id_src1      = near_limit(xorshift());
        if (mode == 1 || (mode >= 2 && r[9])) begin
            id_alu_op = ALU_ADDU;           // base plus small offset
            id_src0   = xorshift() & 32'hffff_fff0;
            id_src1   = xorshift() % 8;
        end
        id_rt_data   = xorshift();
        id_wnum      = 5'(xorshift());
        id_pc        = seq << 2;
        id_exc       = (mode == 2) ? r[10] : (mode == 3 && r[11:10] == 2'b00);
        id_exc_code  = 5'(xorshift());
        id_bad_vaddr = xorshift();
        seq++;
    endtask

    task automatic run_cycle(input int mode);
        logic acc;
        @(negedge clk);
        drive_inputs(mode);
        #1;
        compare_outputs();
        acc = id_valid && !flush && (!m_valid || mem_allowin);
        // handoffs as the dut shows them
        if (exe_valid && flush) flushed++;
        else if (exe_valid && mem_allowin) handed++;
        if (flush) m_valid = 1'b0;
        else if (!m_valid || mem_allowin) m_valid = id_valid;
        if (acc) begin
            m_alu  = id_alu_op;
            m_src0 = id_src0;
            m_src1 = id_src1;
            m_mem  = id_mem_op;
            m_rt   = id_rt_data;
            m_wnum = id_wnum;
            m_pc   = id_pc;
            m_exc  = id_exc;
            m_code = id_exc_code;
            m_bad  = id_bad_vaddr;
            accepted++;
        end
        hold = id_valid && !acc && !flush;
    endtask

    task automatic run_test(input string name, input int mode, input int cycles);
        int err0;
        int chk0;
        int n;
        err0 = errors;
        chk0 = checks;
        accepted = 0;
        handed = 0;
        flushed = 0;
        repeat (cycles) run_cycle(mode);
        n = 0;
        do begin
            run_cycle(4);
            n++;
        end while (exe_valid && n < 20);
        if (exe_valid) begin
            $display("Timeout at %0t: stage did not drain in %0d cycles", $time, n);
            errors++;
        end
        check_value("handoff count", handed + flushed, accepted);
        $display("test %s: %0d checks, %0d errors", name, checks - chk0, errors - err0);
        tests++;
    endtask

    initial begin
        rst_n = 1'b0;
        hold  = 1'b0;
        drive_inputs(4);
        {id_alu_op, id_mem_op, id_src0, id_src1, id_rt_data} = '0;
        {id_wnum, id_pc, id_exc, id_exc_code, id_bad_vaddr} = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        check_value("exe_valid", 32'(exe_valid), 32'd0);
        check_value("exe_allowin", 32'(exe_allowin), 32'd1);
        check_value("dm_we", 32'(dm_we), 32'd0);
        $display("test reset: %0d checks, %0d errors", checks, errors);
        tests++;
        run_test("alu", 0, 600);
        run_test("store and load", 1, 600);
        run_test("decode exception", 2, 600);
        run_test("back-pressure and flush", 3, 800);
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== exe_stage.f ====
source/exe_pkg.sv
source/exe_op_if.sv
source/exe_stage_reg.sv
source/exe_alu.sv
source/store_align.sv
source/exc_resolve.sv
source/exe_stage.sv
verification/exe_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f exe_stage.f --top-module exe_stage_tb -Mdir obj_dir -o exe_stage_sim

out=$(./obj_dir/exe_stage_sim)
echo "$out"

if echo "$out" | grep -qx "All tests passed"; then
    exit 0
else
    exit 1
fi
